// ==== all.f ====
+incdir+logic
logic/fau_pkg.sv
logic/fau_operand_if.sv
logic/fau_add_sub_mod.sv
logic/fau_mont_mult.sv
logic/ecc_fau.sv
sim/ecc_fau_chk.sv
sim/ecc_fau_tb.sv

// ==== logic/ecc_fau.sv ====
//----------------------------------------------------------
// Finite field arithmetic unit for elliptic curve work
// Modular add/subtract and Montgomery multiply on a shared
// operand bus, with registered strobes and ready pulses
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module ecc_fau (
    input  logic              clk,
    input  logic              reset_n,
    // Synchronous clear of all state
    input  logic              zeroize_i,
    input  logic              add_en_i,
    input  logic              sub_i,
    // Level, only its rising edge starts a product
    input  logic              mult_en_i,
    input  fau_pkg::operand_t prime_i,
    input  fau_pkg::digit_t   mult_mu_i,
    input  fau_pkg::operand_t opa_i,
    input  fau_pkg::operand_t opb_i,
    output fau_pkg::operand_t add_res_o,
    output fau_pkg::operand_t mult_res_o,
    output logic              add_ready_o,
    output logic              mult_ready_o
);

    // Registered strobes
    logic add_en;
    logic sub;
    logic mult_start;
    logic mult_start_dly;
    logic mult_start_edge;

    fau_operand_if ops_if ();

    // Operand bus comes straight from the ports
    assign ops_if.opa   = opa_i;
    assign ops_if.opb   = opb_i;
    assign ops_if.prime = prime_i;
    assign ops_if.mu    = mult_mu_i;

    //----------------------------------------------------------
    // Strobe registers
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            add_en         <= 1'b0;
            sub            <= 1'b0;
            mult_start     <= 1'b0;
            mult_start_dly <= 1'b0;
        end else if (zeroize_i) begin
            add_en         <= 1'b0;
            sub            <= 1'b0;
            mult_start     <= 1'b0;
            mult_start_dly <= 1'b0;
        end else begin
            add_en         <= add_en_i;
            sub            <= sub_i;
            mult_start     <= mult_en_i;
            mult_start_dly <= mult_start;
        end
    end

    // One-cycle start on the rising edge of the registered level
    assign mult_start_edge = mult_start & ~mult_start_dly;

    //----------------------------------------------------------
    // Engines
    //----------------------------------------------------------
    fau_add_sub_mod u_add_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (add_en),
        .sub_i     (sub),
        .ops       (ops_if.addsub),
        .res_o     (add_res_o),
        .ready_o   (add_ready_o)
    );

    fau_mont_mult u_mont_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (mult_start_edge),
        .ops       (ops_if.mult),
        .p_o       (mult_res_o),
        .ready_o   (mult_ready_o)
    );

endmodule

`default_nettype wire

// ==== logic/fau_add_sub_mod.sv ====
//----------------------------------------------------------
// Two-stage modular adder/subtractor
// Returns (A+B) mod p or (A-B) mod p two cycles after start
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fau_defines.svh"

module fau_add_sub_mod (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    // Starts an operation, one per cycle at most
    input  logic              add_en_i,
    // Selects subtraction when add_en_i is high
    input  logic              sub_i,
    fau_operand_if.addsub     ops,
    output fau_pkg::operand_t res_o,
    output logic              ready_o
);

    // Raw sum or difference and its corrected companion, one extra bit each
    logic [`FAU_REG_SIZE:0] raw_s;
    logic [`FAU_REG_SIZE:0] corr_s;
    logic [`FAU_REG_SIZE:0] raw_q;
    logic [`FAU_REG_SIZE:0] corr_q;
    logic                   sub_q;
    logic                   valid_q;

    // Stage two
    logic                   use_corr;
    fau_pkg::operand_t      res_q;
    logic                   ready_q;

    //----------------------------------------------------------
    // Stage one
    //----------------------------------------------------------

    // MSB is the carry for add and the borrow for sub
    assign raw_s = sub_i ? ({1'b0, ops.opa} - {1'b0, ops.opb})
                         : ({1'b0, ops.opa} + {1'b0, ops.opb});

    // For add the MSB of corr_s is set when the sum is below p
    assign corr_s = sub_i ? (raw_s + {1'b0, ops.prime})
                          : (raw_s - {1'b0, ops.prime});

    always_ff @(posedge clk) begin
        if (add_en_i) begin
            raw_q  <= raw_s;
            corr_q <= corr_s;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            sub_q   <= 1'b0;
        end else if (zeroize_i) begin
            valid_q <= 1'b0;
            sub_q   <= 1'b0;
        end else begin
            valid_q <= add_en_i;
            sub_q   <= sub_i;
        end
    end

    //----------------------------------------------------------
    // Stage two
    //----------------------------------------------------------

    // Add wraps when it carried or reached p, sub when it borrowed
    assign use_corr = sub_q ? raw_q[`FAU_REG_SIZE]
                            : (raw_q[`FAU_REG_SIZE] | ~corr_q[`FAU_REG_SIZE]);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_q   <= '0;
            ready_q <= 1'b0;
        end else if (zeroize_i) begin
            res_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= valid_q;
            if (valid_q) begin
                res_q <= use_corr ? corr_q[`FAU_REG_SIZE-1:0]
                                  : raw_q[`FAU_REG_SIZE-1:0];
            end
        end
    end

    assign res_o   = res_q;
    assign ready_o = ready_q;

endmodule

`default_nettype wire

// ==== logic/fau_defines.svh ====
//----------------------------------------------------------
// Finite field unit parameters
// Operand width, multiplier digit width and step count
//----------------------------------------------------------

`ifndef FAU_DEFINES_SVH
`define FAU_DEFINES_SVH

// Field element and modulus width in bits
`define FAU_REG_SIZE 32

// Bits of operand A consumed per multiplier step
`define FAU_RADIX 8

// Multiplier steps per operation
`define FAU_DIGITS (`FAU_REG_SIZE / `FAU_RADIX)

`endif

// ==== logic/fau_mont_mult.sv ====
//----------------------------------------------------------
// Digit-serial Montgomery multiplier
// Returns A*B*2^-W mod p, one RADIX digit of A per cycle,
// followed by one conditional subtraction of p
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fau_defines.svh"

module fau_mont_mult (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    // One-cycle start, ignored while busy
    input  logic              start_i,
    fau_operand_if.mult       ops,
    output fau_pkg::operand_t p_o,
    output logic              ready_o
);

    // Accumulator holds T < 2p plus one digit of headroom before the shift
    localparam int ACC_W = `FAU_REG_SIZE + `FAU_RADIX + 2;
    localparam int PAD_W = ACC_W - `FAU_REG_SIZE;
    localparam int DIG_PAD_W = ACC_W - `FAU_RADIX;
    localparam int CNT_W = $clog2(`FAU_DIGITS) + 1;
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`FAU_DIGITS - 1);

    fau_pkg::mm_state_t state;
    logic [CNT_W-1:0]   step_cnt;

    // Captured operands
    fau_pkg::operand_t  a_reg;
    fau_pkg::operand_t  b_reg;
    fau_pkg::operand_t  p_reg;
    fau_pkg::digit_t    mu_reg;

    // Running Montgomery accumulator
    logic [ACC_W-1:0]   t_reg;

    // Result register, visible on p_o
    fau_pkg::operand_t  res_reg;

    // Step datapath
    fau_pkg::digit_t    a_digit;
    fau_pkg::digit_t    q_digit;
    logic [ACC_W-1:0]   b_ext;
    logic [ACC_W-1:0]   p_ext;
    logic [ACC_W-1:0]   t_add_ab;
    logic [ACC_W-1:0]   t_add_qp;
    logic [ACC_W-1:0]   t_next;

    // Final reduction datapath
    logic [ACC_W-1:0]   t_red;
    fau_pkg::operand_t  t_final;

    //----------------------------------------------------------
    // Step and reduction arithmetic
    //----------------------------------------------------------

    // Next digit of A comes from the low end of the shift register
    assign a_digit = a_reg[`FAU_RADIX-1:0];
    assign b_ext   = {{PAD_W{1'b0}}, b_reg};
    assign p_ext   = {{PAD_W{1'b0}}, p_reg};

    // T + a_i * B
    assign t_add_ab = t_reg + ({{DIG_PAD_W{1'b0}}, a_digit} * b_ext);

    // q clears the low digit once q*p is added
    assign q_digit = t_add_ab[`FAU_RADIX-1:0] * mu_reg;

    assign t_add_qp = t_add_ab + ({{DIG_PAD_W{1'b0}}, q_digit} * p_ext);

    // Low digit is zero here, the shift divides by 2^RADIX exactly
    assign t_next = t_add_qp >> `FAU_RADIX;

    // T < 2p after the last step, one subtraction is enough
    assign t_red   = t_reg - p_ext;
    assign t_final = (t_reg >= p_ext) ? t_red[`FAU_REG_SIZE-1:0]
                                      : t_reg[`FAU_REG_SIZE-1:0];

    //----------------------------------------------------------
    // FSM and result register
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= fau_pkg::MM_IDLE;
            step_cnt <= '0;
            res_reg  <= '0;
        end else if (zeroize_i) begin
            // Abort any running product and clear the result
            state    <= fau_pkg::MM_IDLE;
            step_cnt <= '0;
            res_reg  <= '0;
        end else begin
            case (state)
                fau_pkg::MM_IDLE: begin
                    step_cnt <= '0;
                    if (start_i) begin
                        state <= fau_pkg::MM_STEP;
                    end
                end
                fau_pkg::MM_STEP: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP) begin
                        state <= fau_pkg::MM_REDUCE;
                    end
                end
                fau_pkg::MM_REDUCE: begin
                    res_reg <= t_final;
                    state   <= fau_pkg::MM_DONE;
                end
                default: begin
                    // MM_DONE lasts one cycle
                    state <= fau_pkg::MM_IDLE;
                end
            endcase
        end
    end

    //----------------------------------------------------------
    // Operand capture and accumulator
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == fau_pkg::MM_IDLE && start_i) begin
            a_reg  <= ops.opa;
            b_reg  <= ops.opb;
            p_reg  <= ops.prime;
            mu_reg <= ops.mu;
            t_reg  <= '0;
        end else if (state == fau_pkg::MM_STEP) begin
            a_reg <= a_reg >> `FAU_RADIX;
            t_reg <= t_next;
        end
    end

    assign p_o     = res_reg;
    assign ready_o = (state == fau_pkg::MM_DONE);

endmodule

`default_nettype wire

// ==== logic/fau_operand_if.sv ====
//----------------------------------------------------------
// Operand bus of the finite field unit
// Carries A, B, the modulus and the Montgomery constant
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

interface fau_operand_if;

    // Field operands, already reduced below prime
    fau_pkg::operand_t opa;
    fau_pkg::operand_t opb;

    // Odd prime modulus
    fau_pkg::operand_t prime;

    // Low digit of -prime^-1 mod 2^RADIX
    fau_pkg::digit_t mu;

    // Driven from the top level ports
    modport source (output opa, output opb, output prime, output mu);

    // Multiplier needs the full bundle
    modport mult (input opa, input opb, input prime, input mu);

    // Adder/subtractor has no use for mu
    modport addsub (input opa, input opb, input prime);

endinterface

`default_nettype wire

// ==== logic/fau_pkg.sv ====
//----------------------------------------------------------
// Finite field unit types
// Operand and digit vectors, multiplier FSM states
//----------------------------------------------------------

`default_nettype none

`include "fau_defines.svh"

package fau_pkg;

    // Field element, also used for the modulus
    typedef logic [`FAU_REG_SIZE-1:0] operand_t;

    // One radix digit, used for mu and the current digit of A
    typedef logic [`FAU_RADIX-1:0] digit_t;

    // Montgomery multiplier FSM
    typedef enum logic [1:0] {
        MM_IDLE,
        MM_STEP,
        MM_REDUCE,
        MM_DONE
    } mm_state_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the finite field unit testbench with Verilator
set -e

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module ecc_fau_tb

./obj_dir/Vecc_fau_tb | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

exit 0

// ==== sim/ecc_fau_chk.sv ====
//----------------------------------------------------------
// Protocol checker for the finite field unit
// Ready pulse timing and result range assertions
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module ecc_fau_chk (
    input logic              clk,
    input logic              reset_n,
    input logic              zeroize_i,
    input logic              add_en_i,
    input fau_pkg::operand_t prime_i,
    input fau_pkg::operand_t add_res_o,
    input fau_pkg::operand_t mult_res_o,
    input logic              add_ready_o,
    input logic              mult_ready_o
);

    // No ready while in reset
    a_no_ready_in_reset: assert property (@(posedge clk)
        !reset_n |-> (!add_ready_o && !mult_ready_o))
        else $error("ready high during reset");

    // Two-stage add/sub pipeline
    // Ready registers on the second edge after the strobe, seen at the third sample
    a_add_latency: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        add_en_i |-> ##3 add_ready_o)
        else $error("add_ready_o not two cycles after add_en_i");

    // Ready pulses last one cycle
    a_add_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        add_ready_o |=> !add_ready_o)
        else $error("add_ready_o longer than one cycle");

    a_mult_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        mult_ready_o |=> !mult_ready_o)
        else $error("mult_ready_o longer than one cycle");

    // Results are fully reduced
    a_add_range: assert property (@(posedge clk) disable iff (!reset_n)
        add_ready_o |-> (add_res_o < prime_i))
        else $error("add result not below prime");

    a_mult_range: assert property (@(posedge clk) disable iff (!reset_n)
        mult_ready_o |-> (mult_res_o < prime_i))
        else $error("mult result not below prime");

endmodule

bind ecc_fau ecc_fau_chk u_chk (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize_i    (zeroize_i),
    .add_en_i     (add_en_i),
    .prime_i      (prime_i),
    .add_res_o    (add_res_o),
    .mult_res_o   (mult_res_o),
    .add_ready_o  (add_ready_o),
    .mult_ready_o (mult_ready_o)
);

`default_nettype wire

// ==== sim/ecc_fau_tb.sv ====
//----------------------------------------------------------
// Testbench of the finite field unit
// Golden vectors, edge start and zeroize sequences
//----------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module ecc_fau_tb;

    localparam int NUM_VEC   = 24;
    // 24 vectors * (6 latency + 3 idle + 4 margin) + 20
    localparam int MAX_CYCLE = NUM_VEC * (6 + 3 + 4) + 20;
    localparam int ADD_LAT   = 2;
    localparam int MULT_LAT  = 6;

    logic              clk;
    logic              reset_n;
    logic              zeroize_i;
    logic              add_en_i;
    logic              sub_i;
    logic              mult_en_i;
    fau_pkg::operand_t prime_i;
    fau_pkg::digit_t   mult_mu_i;
    fau_pkg::operand_t opa_i;
    fau_pkg::operand_t opb_i;
    fau_pkg::operand_t add_res_o;
    fau_pkg::operand_t mult_res_o;
    logic              add_ready_o;
    logic              mult_ready_o;

    // Golden vectors, opcode 0 add, 1 sub, 2 mult
    int                vec_op  [NUM_VEC];
    fau_pkg::operand_t vec_a   [NUM_VEC];
    fau_pkg::operand_t vec_b   [NUM_VEC];
    fau_pkg::operand_t vec_p   [NUM_VEC];
    fau_pkg::digit_t   vec_mu  [NUM_VEC];
    fau_pkg::operand_t vec_exp [NUM_VEC];

    int cycle_cnt = 0;

    ecc_fau uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .add_en_i     (add_en_i),
        .sub_i        (sub_i),
        .mult_en_i    (mult_en_i),
        .prime_i      (prime_i),
        .mult_mu_i    (mult_mu_i),
        .opa_i        (opa_i),
        .opb_i        (opb_i),
        .add_res_o    (add_res_o),
        .mult_res_o   (mult_res_o),
        .add_ready_o  (add_ready_o),
        .mult_ready_o (mult_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLE) begin
            $display("Timeout: simulation ran past %0d cycles", MAX_CYCLE);
            $display("test failed");
            $fatal(1);
        end
    end

    //----------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------
    task automatic check_operand(input fau_pkg::operand_t expected,
                                 input fau_pkg::operand_t actual,
                                 input int vec, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: vector %0d %s expected %h actual %h",
                     $time, vec, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual,
                               input int vec, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: vector %0d %s expected %b actual %b",
                     $time, vec, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // One clock, then the drive and sample point
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_golden();
        int    fd;
        int    n;
        int    got;
        string line;
        n  = 0;
        fd = $fopen("sim/fau_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("test failed");
            $fatal(1);
        end
        while (!$feof(fd) && n < NUM_VEC) begin
            got = $fgets(line, fd);
            // Skip comments and blank lines
            if (got > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%h %h %h %h %h %h", vec_op[n], vec_a[n],
                              vec_b[n], vec_p[n], vec_mu[n], vec_exp[n]);
                if (got == 6) begin
                    n++;
                end
            end
        end
        $fclose(fd);
        if (n != NUM_VEC) begin
            $display("Golden file holds %0d vectors instead of %0d", n, NUM_VEC);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic drive_operands(input int idx);
        opa_i     = vec_a[idx];
        opb_i     = vec_b[idx];
        prime_i   = vec_p[idx];
        mult_mu_i = vec_mu[idx];
    endtask

    // Strobe, then expect a single ready pulse at the fixed latency
    // Operands stay on the bus through the cycle after the pulse
    task automatic run_vector(input int idx);
        logic is_mult;
        int   lat;
        is_mult = (vec_op[idx] == 2);
        lat     = is_mult ? MULT_LAT : ADD_LAT;
        drive_operands(idx);
        add_en_i  = !is_mult;
        sub_i     = (vec_op[idx] == 1);
        mult_en_i = is_mult;
        for (int k = 0; k <= lat + 1; k++) begin
            next_cycle();
            if (k == 0) begin
                add_en_i  = 1'b0;
                sub_i     = 1'b0;
                mult_en_i = 1'b0;
            end
            check_ready(k == lat, is_mult ? mult_ready_o : add_ready_o, idx, "ready");
            if (k == lat) begin
                check_operand(vec_exp[idx], is_mult ? mult_res_o : add_res_o,
                              idx, "result");
            end
        end
    endtask

    //----------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------
    initial begin
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        add_en_i  = 1'b0;
        sub_i     = 1'b0;
        mult_en_i = 1'b0;
        prime_i   = '0;
        mult_mu_i = '0;
        opa_i     = '0;
        opb_i     = '0;
        void'($urandom(32'h5fcb273d));
        read_golden();

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        next_cycle();

        for (int i = 0; i < NUM_VEC; i++) begin
            run_vector(i);
            repeat ($urandom_range(0, 3)) next_cycle();
        end

        // Level held high gives one product only
        // Window covers the time a level restart would need to finish
        drive_operands(17);
        mult_en_i = 1'b1;
        for (int k = 0; k <= 2 * MULT_LAT + 2; k++) begin
            next_cycle();
            check_ready(k == MULT_LAT, mult_ready_o, 17, "held level ready");
            if (k == MULT_LAT) begin
                check_operand(vec_exp[17], mult_res_o, 17, "held level result");
            end
        end
        mult_en_i = 1'b0;
        next_cycle();

        // Second edge while busy, new operands must not leak in
        drive_operands(17);
        mult_en_i = 1'b1;
        for (int k = 0; k <= 10; k++) begin
            next_cycle();
            if (k == 0) begin
                mult_en_i = 1'b0;
            end else if (k == 1) begin
                mult_en_i = 1'b1;
                opa_i     = vec_a[19];
                opb_i     = vec_b[19];
            end else if (k == 2) begin
                mult_en_i = 1'b0;
            end
            check_ready(k == MULT_LAT, mult_ready_o, 17, "busy start ready");
            if (k == MULT_LAT) begin
                check_operand(vec_exp[17], mult_res_o, 17, "busy start result");
            end
        end

        // Zeroize in the middle of a product
        drive_operands(18);
        mult_en_i = 1'b1;
        for (int k = 0; k <= 10; k++) begin
            next_cycle();
            mult_en_i = 1'b0;
            zeroize_i = (k == 2);
            check_ready(1'b0, mult_ready_o, 18, "ready after zeroize");
        end
        check_operand('0, mult_res_o, 18, "mult result after zeroize");
        check_operand('0, add_res_o, 18, "add result after zeroize");

        run_vector(23);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/fau_golden.txt ====
# op a b prime mu expected, all hex
# op 0 add (a+b) mod p, 1 sub (a-b) mod p, 2 mult a*b*2^-32 mod p
0 00000001 00000002 FFFFFFFB CD 00000003
0 FFFFFFF0 00000010 FFFFFFFB CD 00000005
0 80000000 7FFFFFFB FFFFFFFB CD 00000000
0 FFFFFFFA FFFFFFFA FFFFFFFB CD FFFFFFF9
0 7FFFFFF0 00000020 7FFFFFFF 01 00000011
0 00000100 00000200 7FFFFFFF 01 00000300
1 00000005 00000003 FFFFFFFB CD 00000002
1 00000003 00000005 FFFFFFFB CD FFFFFFF9
1 12345678 12345678 FFFFFFFB CD 00000000
1 00000000 FFFFFFFA FFFFFFFB CD 00000001
1 00000001 7FFFFFFE 7FFFFFFF 01 00000002
1 40000000 00000001 7FFFFFFF 01 3FFFFFFF
2 00000000 12345678 FFFFFFFB CD 00000000
2 00000005 00000001 FFFFFFFB CD 00000001
2 00000001 00000001 FFFFFFFB CD CCCCCCC9
2 FFFFFFFA 00000001 FFFFFFFB CD 33333332
2 FFFFFFFA FFFFFFFA FFFFFFFB CD CCCCCCC9
2 0000000A 00000007 FFFFFFFB CD 0000000E
2 00000005 12345678 FFFFFFFB CD 12345678
2 FFFFFFFA 00000005 FFFFFFFB CD FFFFFFFA
2 00000002 00001234 7FFFFFFF 01 00001234
2 00000006 00000007 7FFFFFFF 01 00000015
2 7FFFFFFE 00000002 7FFFFFFF 01 7FFFFFFE
2 00000001 00000001 7FFFFFFF 01 40000000
